// ==== src/cipher_cfg.svh ====
/*
 * Cipher machine configuration.
 * Fixed sizes of the letter datapath, the AXI4-Lite bus
 * and the register map offsets.
 */
`ifndef CIPHER_CFG_SVH
`define CIPHER_CFG_SVH

// Letters per string.
`define CIPHER_CHARS 5
// Bits per letter code.
`define CIPHER_LETTER_W 5
// Modulus of the alphabet, a = 0 to z = 25.
`define CIPHER_ALPHABET 26
// Whole string, letter 0 in the top bits.
`define CIPHER_STRING_W 25
// Enough to count five letters.
`define CIPHER_INDEX_W 3

// Bus widths.
`define AXI_ADDR_W 5
`define AXI_DATA_W 32

// Register map.
`define REG_CTRL 5'h00
`define REG_STATUS 5'h04
`define REG_TEXT 5'h08
`define REG_KEY 5'h0C
`define REG_RESULT 5'h10

`endif

// ==== src/cipher_pkg.sv ====
/*
 * Cipher machine types.
 * Method and sequencer state encodings, and the structs
 * carried between register block, sequencer and shifter.
 */
`include "cipher_cfg.svh"
`default_nettype none

package cipher_pkg;

	// Method field of CTRL; the last code is a second plain.
	typedef enum logic [1:0]
	{
		METHOD_PLAIN = 2'd0,
		METHOD_CAESAR = 2'd1,
		METHOD_VIGENERE = 2'd2,
		METHOD_PLAIN_ALT = 2'd3
	} cipher_method_e;

	// Sequencer states.
	typedef enum logic [1:0]
	{
		SEQ_IDLE = 2'd0,
		SEQ_ISSUE = 2'd1,
		SEQ_DRAIN = 2'd2
	} seq_state_e;

	// One letter code.
	typedef logic [`CIPHER_LETTER_W-1:0] letter_t;

	// Command from the register block.
	typedef struct packed
	{
		logic start;
		cipher_method_e method;
		logic encode;
		logic [`CIPHER_STRING_W-1:0] text;
		logic [`CIPHER_STRING_W-1:0] key;
	} cipher_cmd_t;

	// Status back to the register block.
	typedef struct packed
	{
		logic busy;
		logic done;
		logic [`CIPHER_STRING_W-1:0] result;
	} cipher_status_t;

	// One letter into the shifter.
	typedef struct packed
	{
		logic valid;
		logic [`CIPHER_INDEX_W-1:0] index;
		letter_t letter;
		letter_t shift;
		logic encode;
	} shift_req_t;

	// One processed letter out of the shifter.
	typedef struct packed
	{
		logic valid;
		logic [`CIPHER_INDEX_W-1:0] index;
		letter_t letter;
	} shift_rsp_t;

endpackage

`default_nettype wire

// ==== src/letter_shifter.sv ====
/*
 * Letter shifter.
 * Adds or subtracts a shift modulo 26 on one letter code,
 * registered so a new letter enters every cycle.
 */
`include "cipher_cfg.svh"
`default_nettype none

module letter_shifter
(
	input wire logic clock,
	input wire logic resetn,
	input wire cipher_pkg::shift_req_t req,
	output cipher_pkg::shift_rsp_t rsp
);

	import cipher_pkg::*;

	localparam logic [`CIPHER_LETTER_W:0] ALPHA = (`CIPHER_LETTER_W + 1)'(`CIPHER_ALPHABET);

	letter_t shift_mod;
	letter_t shifted;
	logic [`CIPHER_LETTER_W:0] sum;

	always_comb
	begin
		// Key letters above z fold back once.
		if ({1'b0, req.shift} >= ALPHA)
			shift_mod = req.shift - ALPHA[`CIPHER_LETTER_W-1:0];
		else
			shift_mod = req.shift;

		// Decode adds the complement, so both sides need one fold.
		if (req.encode)
			sum = {1'b0, req.letter} + {1'b0, shift_mod};
		else
			sum = {1'b0, req.letter} + ALPHA - {1'b0, shift_mod};
		if (sum >= ALPHA)
			sum = sum - ALPHA;

		// Codes 26 to 31 are not letters.
		if ({1'b0, req.letter} >= ALPHA)
			shifted = req.letter;
		else
			shifted = sum[`CIPHER_LETTER_W-1:0];
	end

	// Valid stage.
	always_ff @(posedge clock)
	begin
		if (!resetn)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= req.valid;
	end

	// Payload stage.
	always_ff @(posedge clock)
	begin
		rsp.index <= req.index;
		rsp.letter <= shifted;
	end

endmodule

`default_nettype wire

// ==== src/cipher_sequencer.sv ====
/*
 * Cipher sequencer.
 * Latches a command, issues one letter per cycle to the
 * shifter with the shift for the chosen method, and gathers
 * the returned letters into the result string.
 */
`include "cipher_cfg.svh"
`default_nettype none

module cipher_sequencer
(
	input wire logic clock,
	input wire logic resetn,
	input wire cipher_pkg::cipher_cmd_t cmd,
	output cipher_pkg::cipher_status_t status,
	output cipher_pkg::shift_req_t req,
	input wire cipher_pkg::shift_rsp_t rsp
);

	import cipher_pkg::*;

	localparam logic [`CIPHER_INDEX_W-1:0] LAST_INDEX = `CIPHER_INDEX_W'(`CIPHER_CHARS - 1);

	seq_state_e state;
	logic start_accept;
	logic [`CIPHER_INDEX_W-1:0] issue_idx;
	logic [`CIPHER_INDEX_W-1:0] rsp_cnt;
	logic done_q;
	cipher_method_e method_q;
	logic encode_q;
	letter_t text_q [`CIPHER_CHARS];
	letter_t key_q [`CIPHER_CHARS];
	letter_t result_q [`CIPHER_CHARS];
	letter_t shift;

	// A start outside idle is dropped.
	assign start_accept = (state == SEQ_IDLE) && cmd.start;

	// Control state.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= SEQ_IDLE;
			issue_idx <= '0;
			rsp_cnt <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (cmd.start)
					begin
						issue_idx <= '0;
						rsp_cnt <= '0;
						done_q <= 1'b0;
						state <= SEQ_ISSUE;
					end
				end
				// One letter leaves per cycle.
				SEQ_ISSUE:
				begin
					issue_idx <= issue_idx + 1'b1;
					if (issue_idx == LAST_INDEX)
						state <= SEQ_DRAIN;
				end
				// Wait for the tail of the pipeline.
				SEQ_DRAIN:
				begin
					if (rsp.valid && rsp_cnt == LAST_INDEX)
					begin
						done_q <= 1'b1;
						state <= SEQ_IDLE;
					end
				end
				default:
					state <= SEQ_IDLE;
			endcase

			// Responses can overlap with issue.
			if (rsp.valid)
				rsp_cnt <= rsp_cnt + 1'b1;
		end
	end

	// Command copy, held for the whole run.
	always_ff @(posedge clock)
	begin
		if (start_accept)
		begin
			method_q <= cmd.method;
			encode_q <= cmd.encode;
			for (int i = 0; i < `CIPHER_CHARS; i++)
			begin
				text_q[i] <= cmd.text[(`CIPHER_CHARS-1-i)*`CIPHER_LETTER_W +: `CIPHER_LETTER_W];
				key_q[i] <= cmd.key[(`CIPHER_CHARS-1-i)*`CIPHER_LETTER_W +: `CIPHER_LETTER_W];
			end
		end
	end

	// Result letters land by returned index.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < `CIPHER_CHARS; i++)
				result_q[i] <= '0;
		end
		else if (rsp.valid)
			result_q[rsp.index] <= rsp.letter;
	end

	// Shift per method.
	// Caesar is Vigenere with key letter 0 everywhere.
	always_comb
	begin
		case (method_q)
			METHOD_CAESAR:
				shift = key_q[0];
			METHOD_VIGENERE:
				shift = key_q[issue_idx];
			default:
				shift = '0;
		endcase
	end

	// Letter request.
	always_comb
	begin
		req.valid = (state == SEQ_ISSUE);
		req.index = issue_idx;
		req.letter = text_q[issue_idx];
		req.shift = shift;
		req.encode = encode_q;
	end

	// Status, letter 0 in the top bits.
	always_comb
	begin
		status.busy = (state != SEQ_IDLE);
		status.done = done_q;
		for (int i = 0; i < `CIPHER_CHARS; i++)
			status.result[(`CIPHER_CHARS-1-i)*`CIPHER_LETTER_W +: `CIPHER_LETTER_W] = result_q[i];
	end

endmodule

`default_nettype wire

// ==== src/cipher_regs.sv ====
/*
 * Cipher register block.
 * AXI4-Lite slave holding text, key and control fields.
 * Generates the one-cycle start pulse and returns
 * status and result on reads.
 */
`include "cipher_cfg.svh"
`default_nettype none

module cipher_regs
(
	input wire logic clock,
	input wire logic resetn,

	// Write address and data.
	input wire logic [`AXI_ADDR_W-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [`AXI_DATA_W-1:0] wdata,
	input wire logic [3:0] wstrb,
	input wire logic wvalid,
	output logic wready,

	// Write response.
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,

	// Read address and data.
	input wire logic [`AXI_ADDR_W-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [`AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready,

	// Core side.
	output cipher_pkg::cipher_cmd_t cmd,
	input wire cipher_pkg::cipher_status_t status
);

	import cipher_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic wr_ready_q;
	logic write_fire;
	logic read_fire;
	logic start_q;
	cipher_method_e method_q;
	logic encode_q;
	logic [`CIPHER_STRING_W-1:0] text_q;
	logic [`CIPHER_STRING_W-1:0] key_q;
	logic [`AXI_DATA_W-1:0] read_mux;

	// Address and data are taken together.
	assign awready = wr_ready_q;
	assign wready = wr_ready_q;
	assign write_fire = wr_ready_q && awvalid && wvalid;
	assign read_fire = arready && arvalid;

	// Every access succeeds.
	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	// Write channel.
	// Ready pulses once per accepted pair, never while a response waits.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			wr_ready_q <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			wr_ready_q <= awvalid && wvalid && !bvalid && !wr_ready_q;
			if (write_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Register writes.
	// Only whole words are written, so wstrb plays no part in the decode.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			start_q <= 1'b0;
			method_q <= METHOD_PLAIN;
			encode_q <= 1'b0;
			text_q <= '0;
			key_q <= '0;
		end
		else
		begin
			// Start lasts a single cycle.
			start_q <= 1'b0;
			if (write_fire)
			begin
				case (awaddr)
					`REG_CTRL:
					begin
						start_q <= wdata[0];
						method_q <= cipher_method_e'(wdata[2:1]);
						encode_q <= wdata[3];
					end
					`REG_TEXT:
						text_q <= wdata[`CIPHER_STRING_W-1:0];
					`REG_KEY:
						key_q <= wdata[`CIPHER_STRING_W-1:0];
					// Status, result and holes are read only.
					default:
						;
				endcase
			end
		end
	end

	// Command to the sequencer.
	always_comb
	begin
		cmd.start = start_q;
		cmd.method = method_q;
		cmd.encode = encode_q;
		cmd.text = text_q;
		cmd.key = key_q;
	end

	// Read channel handshake.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (read_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Read data select.
	// Start is never stored, so it reads as zero.
	always_comb
	begin
		read_mux = '0;
		case (araddr)
			`REG_CTRL:
				read_mux[3:0] = {encode_q, method_q, 1'b0};
			`REG_STATUS:
				read_mux[1:0] = {status.done, status.busy};
			`REG_TEXT:
				read_mux[`CIPHER_STRING_W-1:0] = text_q;
			`REG_KEY:
				read_mux[`CIPHER_STRING_W-1:0] = key_q;
			`REG_RESULT:
				read_mux[`CIPHER_STRING_W-1:0] = status.result;
			default:
				read_mux = '0;
		endcase
	end

	// Read data held until rready.
	always_ff @(posedge clock)
	begin
		if (read_fire)
			rdata <= read_mux;
	end

endmodule

`default_nettype wire

// ==== src/cipher_machine.sv ====
/*
 * Cipher machine top level.
 * AXI4-Lite register block driving one sequencer and one
 * pipelined letter shifter.
 */
`include "cipher_cfg.svh"
`default_nettype none

module cipher_machine
(
	input wire logic clock,
	input wire logic resetn,
	input wire logic [`AXI_ADDR_W-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [`AXI_DATA_W-1:0] wdata,
	input wire logic [3:0] wstrb,
	input wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [`AXI_ADDR_W-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic [`AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready
);

	import cipher_pkg::*;

	// Register block to sequencer.
	cipher_cmd_t cmd;
	cipher_status_t status;
	// Sequencer to shifter and back.
	shift_req_t req;
	shift_rsp_t rsp;

	cipher_regs u_regs
	(
		.clock(clock),
		.resetn(resetn),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.cmd(cmd),
		.status(status)
	);

	cipher_sequencer u_sequencer
	(
		.clock(clock),
		.resetn(resetn),
		.cmd(cmd),
		.status(status),
		.req(req),
		.rsp(rsp)
	);

	letter_shifter u_shifter
	(
		.clock(clock),
		.resetn(resetn),
		.req(req),
		.rsp(rsp)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_cipher_machine.sv ====
/*
 * Cipher machine testbench.
 * Drives the AXI4-Lite bus with random texts and keys,
 * computes expected strings with a reference model and
 * compares RESULT in a separate checking process.
 */
`include "cipher_cfg.svh"
`default_nettype none

module tb_cipher_machine;

	timeunit 1ns;
	timeprecision 1ps;

	import cipher_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DELAY = 2;
	localparam int PAIRS = 20;
	localparam int POLL_LIMIT = 50;
	// Caesar 4 runs per pair, Vigenere 2, plus plain and busy runs.
	localparam int NUM_CMDS = 6 * PAIRS + 4 + 3 + 2;
	localparam int WATCHDOG_CYCLES = NUM_CMDS * 200 + RESET_CYCLES;

	logic clock;
	logic resetn;
	logic [`AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`AXI_DATA_W-1:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] rng_state = 32'he031;
	int errors = 0;
	int checks = 0;
	// Pending comparisons, filled by the stimulus.
	string what_q[$];
	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];

	cipher_machine dut_i
	(
		.clock(clock),
		.resetn(resetn),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	// 40 ns period.
	always #20 clock = ~clock;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// About one code in eight lies above z.
	function automatic logic [4:0] random_letter();
		logic [31:0] r;
		int code;
		r = next_random();
		if (r[2:0] == 3'd0)
		begin
			code = 26 + int'(r[10:3]) % 6;
		end
		else
		begin
			code = int'(r[20:8]) % 26;
		end
		return 5'(code);
	endfunction

	// Letter 0 sits in the top five bits.
	function automatic logic [`CIPHER_STRING_W-1:0] random_string();
		logic [`CIPHER_STRING_W-1:0] s;
		for (int i = 0; i < `CIPHER_CHARS; i++)
			s[(`CIPHER_CHARS-1-i)*`CIPHER_LETTER_W +: `CIPHER_LETTER_W] = random_letter();
		return s;
	endfunction

	// Expected string from the letter rules.
	function automatic logic [`CIPHER_STRING_W-1:0] cipher_ref
	(
		input logic [`CIPHER_STRING_W-1:0] text,
		input logic [`CIPHER_STRING_W-1:0] key,
		input cipher_method_e method,
		input logic encode
	);
		logic [`CIPHER_STRING_W-1:0] res;
		int pos;
		int l;
		int s;
		for (int i = 0; i < `CIPHER_CHARS; i++)
		begin
			pos = (`CIPHER_CHARS - 1 - i) * `CIPHER_LETTER_W;
			l = int'(text[pos +: `CIPHER_LETTER_W]);
			// Caesar always uses key letter 0.
			case (method)
				METHOD_CAESAR:
					s = int'(key[`CIPHER_STRING_W-1 -: `CIPHER_LETTER_W]);
				METHOD_VIGENERE:
					s = int'(key[pos +: `CIPHER_LETTER_W]);
				default:
					s = 0;
			endcase
			s = s % 26;
			if (l < 26)
				l = encode ? (l + s) % 26 : (l + 26 - s) % 26;
			res[pos +: `CIPHER_LETTER_W] = 5'(l);
		end
		return res;
	endfunction

	function automatic void expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		what_q.push_back(what);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endfunction

	// Called at a drive point, returns at one.
	task automatic axil_write(input logic [`AXI_ADDR_W-1:0] addr,
		input logic [`AXI_DATA_W-1:0] data);
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		// Ready seen here is taken at the next edge.
		while (!awready)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
		// Both ready lines pulse in the same cycle.
		expect_equal("wready", 32'(wready), 32'h1);
		@(posedge clock);
		#DRIVE_DELAY;
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
		expect_equal("bresp", 32'(bresp), 32'h0);
		@(posedge clock);
		#DRIVE_DELAY;
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [`AXI_ADDR_W-1:0] addr,
		output logic [`AXI_DATA_W-1:0] data);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		while (!arready)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
		@(posedge clock);
		#DRIVE_DELAY;
		arvalid = 1'b0;
		while (!rvalid)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
		data = rdata;
		expect_equal("rresp", 32'(rresp), 32'h0);
		@(posedge clock);
		#DRIVE_DELAY;
		rready = 1'b0;
	endtask

	// CTRL: start in bit 0, method in 2:1, encode in 3.
	task automatic start_command(input cipher_method_e method, input logic encode);
		axil_write(`REG_CTRL, {28'd0, encode, method, 1'b1});
	endtask

	task automatic wait_done();
		logic [31:0] data;
		int polls;
		data = '0;
		polls = 0;
		while (!data[1] && polls < POLL_LIMIT)
		begin
			axil_read(`REG_STATUS, data);
			polls++;
		end
		assert (data[1])
		else
		begin
			$display("error: STATUS.done did not rise after %0d polls", polls);
			errors++;
		end
	endtask

	task automatic run_command(input logic [`CIPHER_STRING_W-1:0] text,
		input logic [`CIPHER_STRING_W-1:0] key, input cipher_method_e method,
		input logic encode, output logic [`CIPHER_STRING_W-1:0] result);
		logic [31:0] data;
		axil_write(`REG_TEXT, 32'(text));
		axil_write(`REG_KEY, 32'(key));
		start_command(method, encode);
		wait_done();
		axil_read(`REG_RESULT, data);
		result = data[`CIPHER_STRING_W-1:0];
	endtask

	// Compares everything the stimulus queued.
	initial
	begin
		forever
		begin
			@(posedge clock);
			while (got_q.size() != 0)
			begin
				checks++;
				assert (got_q[0] === exp_q[0])
				else
				begin
					$display("mismatch %s: got %h, expected %h", what_q[0], got_q[0], exp_q[0]);
					errors++;
				end
				void'(what_q.pop_front());
				void'(got_q.pop_front());
				void'(exp_q.pop_front());
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] data;
		logic [`CIPHER_STRING_W-1:0] text;
		logic [`CIPHER_STRING_W-1:0] key;
		logic [`CIPHER_STRING_W-1:0] alt_key;
		logic [`CIPHER_STRING_W-1:0] tail;
		logic [`CIPHER_STRING_W-1:0] result;
		logic [`CIPHER_STRING_W-1:0] back;
		cipher_method_e method;

		clock = 1'b0;
		resetn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		resetn = 1'b1;

		// Everything reads zero after reset.
		axil_read(`REG_STATUS, data);
		expect_equal("STATUS after reset", data, 32'h0);
		axil_read(`REG_RESULT, data);
		expect_equal("RESULT after reset", data, 32'h0);
		axil_read(`REG_TEXT, data);
		expect_equal("TEXT after reset", data, 32'h0);
		axil_read(`REG_KEY, data);
		expect_equal("KEY after reset", data, 32'h0);
		axil_read(`REG_CTRL, data);
		expect_equal("CTRL after reset", data, 32'h0);
		text = random_string();
		key = random_string();
		axil_write(`REG_TEXT, 32'(text));
		axil_write(`REG_KEY, 32'(key));
		axil_read(`REG_TEXT, data);
		expect_equal("TEXT readback", data, 32'(text));
		axil_read(`REG_KEY, data);
		expect_equal("KEY readback", data, 32'(key));

		// Caesar, then the same key with new letters 1 to 4.
		for (int n = 0; n < PAIRS; n++)
		begin
			text = random_string();
			key = random_string();
			tail = random_string();
			alt_key = {key[`CIPHER_STRING_W-1 -: `CIPHER_LETTER_W],
				tail[`CIPHER_STRING_W-`CIPHER_LETTER_W-1:0]};
			for (int e = 0; e < 2; e++)
			begin
				run_command(text, key, METHOD_CAESAR, e[0], result);
				expect_equal("RESULT caesar", 32'(result),
					32'(cipher_ref(text, key, METHOD_CAESAR, e[0])));
				run_command(text, alt_key, METHOD_CAESAR, e[0], result);
				expect_equal("RESULT caesar key tail", 32'(result),
					32'(cipher_ref(text, key, METHOD_CAESAR, e[0])));
			end
		end

		// Vigenere round trip.
		for (int n = 0; n < PAIRS; n++)
		begin
			text = random_string();
			key = random_string();
			run_command(text, key, METHOD_VIGENERE, 1'b1, result);
			expect_equal("RESULT vigenere encode", 32'(result),
				32'(cipher_ref(text, key, METHOD_VIGENERE, 1'b1)));
			run_command(result, key, METHOD_VIGENERE, 1'b0, back);
			expect_equal("RESULT vigenere decode", 32'(back), 32'(text));
		end

		// Plain methods with non-letter codes in the text.
		text = {5'd0, 5'd26, 5'd31, 5'd13, 5'd25};
		key = random_string();
		for (int m = 0; m < 2; m++)
		begin
			method = (m == 0) ? METHOD_PLAIN : METHOD_PLAIN_ALT;
			for (int e = 0; e < 2; e++)
			begin
				run_command(text, key, method, e[0], result);
				expect_equal("RESULT plain", 32'(result), 32'(text));
			end
		end

		// Second start lands while the first run is busy.
		text = random_string();
		key = random_string();
		axil_write(`REG_TEXT, 32'(text));
		axil_write(`REG_KEY, 32'(key));
		start_command(METHOD_VIGENERE, 1'b1);
		fork
			axil_read(`REG_STATUS, data);
			start_command(METHOD_CAESAR, 1'b0);
		join
		expect_equal("STATUS.busy at second start", 32'(data[0]), 32'h1);
		wait_done();
		axil_read(`REG_RESULT, data);
		expect_equal("RESULT first of two starts", data,
			32'(cipher_ref(text, key, METHOD_VIGENERE, 1'b1)));
		// No hidden second run follows.
		axil_read(`REG_STATUS, data);
		expect_equal("STATUS after first run", data, 32'h2);
		start_command(METHOD_CAESAR, 1'b0);
		axil_read(`REG_STATUS, data);
		expect_equal("STATUS during new run", data, 32'h1);
		wait_done();
		axil_read(`REG_RESULT, data);
		expect_equal("RESULT new run", data,
			32'(cipher_ref(text, key, METHOD_CAESAR, 1'b0)));

		// Let the checker empty its queue.
		repeat (2) @(posedge clock);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/cipher_pkg.sv
src/letter_shifter.sv
src/cipher_sequencer.sv
src/cipher_regs.sv
src/cipher_machine.sv
testbench/tb_cipher_machine.sv

// ==== run.sh ====
#!/bin/sh
# Builds the cipher machine testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
	--top-module tb_cipher_machine -o tb_cipher_machine

output=$(./obj_dir/tb_cipher_machine)
echo "$output"
if echo "$output" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1
